//--- include/l2_cache_defs.svh
//////////////////////////////////////////////////////////////////////
// geometry macros for the two-way L2 cache
// 8 sets, 32-byte lines, 32-bit byte addresses
//////////////////////////////////////////////////////////////////////
`ifndef L2_CACHE_DEFS_SVH
`define L2_CACHE_DEFS_SVH

// address split
`define L2_S_OFFSET 5	// byte within the line
`define L2_S_INDEX  3	// set select
`define L2_S_TAG    24	// remaining upper bits

// line geometry
`define L2_S_MASK   32	// bytes per line, one enable bit each
`define L2_S_LINE   256	// bits per line
`define L2_NUM_SETS 8

`endif

//--- src/l2_cache_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types of the L2 cache
// address union and the mux select encodings
//////////////////////////////////////////////////////////////////////
`include "l2_cache_defs.svh"

package l2_cache_pkg;

	// one address word, seen flat or split into its fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [`L2_S_TAG-1:0]    tag;
			logic [`L2_S_INDEX-1:0]  index;
			logic [`L2_S_OFFSET-1:0] offset;
		} fields;
	} l2_addr_t;

	// byte write enable source of a data array
	typedef enum logic [1:0] {zero, all_ones, byte_enable} data_write_en_sel_e;

	// line returned to the cpu and sent on write-back
	typedef enum logic [1:0] {data0_hit, data1_hit, no_hit} data_out_sel_e;

	// line written into a data array
	typedef enum logic [1:0] {r_data_mod, w_data, r_data} data_datain_sel_e;

	// memory address source
	typedef enum logic [1:0] {cpu_addr, tag0_addr, tag1_addr} mem_addr_sel_e;

endpackage

//--- src/l2_cache_array.sv
//////////////////////////////////////////////////////////////////////
// per-set storage for tag, valid, dirty and lru bits
// registered read, load forwards to the output
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_cache_array #(
	parameter int width = 1
) (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    read_i,
	input  logic                    load_i,
	input  logic [`L2_S_INDEX-1:0]  index_i,
	input  logic [width-1:0]        datain_i,
	output logic [width-1:0]        dataout_o
);

	logic [width-1:0] entries [`L2_NUM_SETS];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int s = 0; s < `L2_NUM_SETS; s++) begin
				entries[s] <= '0;
			end
			dataout_o <= '0;
		end else if (load_i) begin
			entries[index_i] <= datain_i;
			dataout_o <= datain_i;	// new value visible next cycle
		end else if (read_i) begin
			dataout_o <= entries[index_i];
		end
	end

endmodule

//--- src/l2_cache_data_array.sv
//////////////////////////////////////////////////////////////////////
// per-set line store with byte write enables
// registered read with write forwarding
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_cache_data_array (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    read_i,
	input  logic [`L2_S_MASK-1:0]   write_en_i,
	input  logic [`L2_S_INDEX-1:0]  index_i,
	input  logic [`L2_S_LINE-1:0]   datain_i,
	output logic [`L2_S_LINE-1:0]   dataout_o
);

	logic [`L2_S_LINE-1:0] lines [`L2_NUM_SETS];
	logic [`L2_S_LINE-1:0] merged;	// stored line with enabled bytes replaced

	always_comb begin
		for (int i = 0; i < `L2_S_MASK; i++) begin
			merged[8*i +: 8] = write_en_i[i] ? datain_i[8*i +: 8] : lines[index_i][8*i +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (|write_en_i) begin
			lines[index_i] <= merged;
		end
	end

	// with no enables set, merged is just the stored line
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dataout_o <= '0;
		end else if (read_i || |write_en_i) begin
			dataout_o <= merged;
		end
	end

endmodule

//--- src/l2_cache_datapath.sv
//////////////////////////////////////////////////////////////////////
// L2 cache datapath
// data, tag, valid, dirty and lru arrays, tag compare, byte merge
// and the data and address select muxes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_cache_datapath (
	input  logic                                    clk,
	input  logic                                    arst_n_i,
	input  logic [31:0]                             cpu_address_i,
	input  logic [`L2_S_LINE-1:0]                   cpu_wdata_i,
	input  logic [`L2_S_MASK-1:0]                   cpu_byte_enable_i,
	input  logic [`L2_S_LINE-1:0]                   mem_rdata_i,
	input  logic                                    tag0_load,
	input  logic                                    tag1_load,
	input  logic                                    valid0_load,
	input  logic                                    valid0_datain,
	input  logic                                    valid1_load,
	input  logic                                    valid1_datain,
	input  logic                                    dirty0_load,
	input  logic                                    dirty0_datain,
	input  logic                                    dirty1_load,
	input  logic                                    dirty1_datain,
	input  logic                                    lru_load,
	input  logic                                    lru_datain,
	input  logic                                    arr_read,
	input  l2_cache_pkg::data_write_en_sel_e        data0_write_en_sel,
	input  l2_cache_pkg::data_write_en_sel_e        data1_write_en_sel,
	input  l2_cache_pkg::data_out_sel_e             data_out_sel,
	input  l2_cache_pkg::data_datain_sel_e          data0_datain_sel,
	input  l2_cache_pkg::data_datain_sel_e          data1_datain_sel,
	input  l2_cache_pkg::mem_addr_sel_e             mem_addr_sel,
	output logic [`L2_S_LINE-1:0]                   cpu_rdata_o,
	output logic [`L2_S_LINE-1:0]                   mem_wdata_o,
	output logic [31:0]                             mem_address_o,
	output logic                                    hit,
	output logic                                    tag0_comp,
	output logic                                    tag1_comp,
	output logic                                    lru_dataout,
	output logic                                    valid0_dataout,
	output logic                                    valid1_dataout,
	output logic                                    dirty0_dataout,
	output logic                                    dirty1_dataout
);

	l2_cache_pkg::l2_addr_t addr;
	logic [1:0]             tag_load, valid_load, valid_datain, dirty_load, dirty_datain;
	logic [1:0]             tag_match, valid_out, dirty_out;
	logic [`L2_S_TAG-1:0]   tag_out [2];
	logic [`L2_S_LINE-1:0]  line_out [2];
	logic [`L2_S_LINE-1:0]  fill_merged;	// memory line with cpu write bytes on top
	logic [`L2_S_LINE-1:0]  out_line;

	assign addr.raw     = cpu_address_i;
	assign tag_load     = {tag1_load, tag0_load};
	assign valid_load   = {valid1_load, valid0_load};
	assign valid_datain = {valid1_datain, valid0_datain};
	assign dirty_load   = {dirty1_load, dirty0_load};
	assign dirty_datain = {dirty1_datain, dirty0_datain};

	always_comb begin
		for (int i = 0; i < `L2_S_MASK; i++) begin
			fill_merged[8*i +: 8] = cpu_byte_enable_i[i] ? cpu_wdata_i[8*i +: 8]
			                                             : mem_rdata_i[8*i +: 8];
		end
	end

	for (genvar w = 0; w < 2; w++) begin : g_way
		l2_cache_pkg::data_write_en_sel_e we_sel;
		l2_cache_pkg::data_datain_sel_e   din_sel;
		logic [`L2_S_MASK-1:0]            write_en;
		logic [`L2_S_LINE-1:0]            line_in;

		assign we_sel  = (w == 0) ? data0_write_en_sel : data1_write_en_sel;
		assign din_sel = (w == 0) ? data0_datain_sel : data1_datain_sel;
		assign tag_match[w] = tag_out[w] == addr.fields.tag;

		always_comb begin
			case (we_sel)
				l2_cache_pkg::all_ones:    write_en = '1;	// whole line on fill
				l2_cache_pkg::byte_enable: write_en = cpu_byte_enable_i;
				default:                   write_en = '0;
			endcase
			case (din_sel)
				l2_cache_pkg::r_data_mod: line_in = fill_merged;
				l2_cache_pkg::r_data:     line_in = mem_rdata_i;
				default:                  line_in = cpu_wdata_i;
			endcase
		end

		l2_cache_data_array u_data (
			.clk        (clk),
			.arst_n_i   (arst_n_i),
			.read_i     (arr_read),
			.write_en_i (write_en),
			.index_i    (addr.fields.index),
			.datain_i   (line_in),
			.dataout_o  (line_out[w])
		);

		l2_cache_array #(.width(`L2_S_TAG)) u_tag (
			.clk       (clk),
			.arst_n_i  (arst_n_i),
			.read_i    (arr_read),
			.load_i    (tag_load[w]),
			.index_i   (addr.fields.index),
			.datain_i  (addr.fields.tag),
			.dataout_o (tag_out[w])
		);

		l2_cache_array #(.width(1)) u_valid (
			.clk       (clk),
			.arst_n_i  (arst_n_i),
			.read_i    (arr_read),
			.load_i    (valid_load[w]),
			.index_i   (addr.fields.index),
			.datain_i  (valid_datain[w]),
			.dataout_o (valid_out[w])
		);

		l2_cache_array #(.width(1)) u_dirty (
			.clk       (clk),
			.arst_n_i  (arst_n_i),
			.read_i    (arr_read),
			.load_i    (dirty_load[w]),
			.index_i   (addr.fields.index),
			.datain_i  (dirty_datain[w]),
			.dataout_o (dirty_out[w])
		);
	end

	// lru bit names the way to evict next
	l2_cache_array #(.width(1)) u_lru (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.read_i    (arr_read),
		.load_i    (lru_load),
		.index_i   (addr.fields.index),
		.datain_i  (lru_datain),
		.dataout_o (lru_dataout)
	);

	assign tag0_comp      = tag_match[0];
	assign tag1_comp      = tag_match[1];
	assign valid0_dataout = valid_out[0];
	assign valid1_dataout = valid_out[1];
	assign dirty0_dataout = dirty_out[0];
	assign dirty1_dataout = dirty_out[1];
	assign hit            = |(tag_match & valid_out);
	assign cpu_rdata_o    = out_line;
	assign mem_wdata_o    = out_line;	// victim line during write-back

	always_comb begin
		case (data_out_sel)
			l2_cache_pkg::data0_hit: out_line = line_out[0];
			l2_cache_pkg::data1_hit: out_line = line_out[1];
			default:                 out_line = '0;
		endcase
		case (mem_addr_sel)
			l2_cache_pkg::tag0_addr:
				mem_address_o = {tag_out[0], addr.fields.index, {`L2_S_OFFSET{1'b0}}};
			l2_cache_pkg::tag1_addr:
				mem_address_o = {tag_out[1], addr.fields.index, {`L2_S_OFFSET{1'b0}}};
			default:
				mem_address_o = {addr.fields.tag, addr.fields.index, {`L2_S_OFFSET{1'b0}}};
		endcase
	end

	// a fill only replaces a way that missed, so one set never holds a tag twice
	assert property (@(posedge clk) disable iff (!arst_n_i) !(&(tag_match & valid_out)));

endmodule

//--- src/l2_cache_control.sv
//////////////////////////////////////////////////////////////////////
// L2 cache control FSM
// hit, write-back and fill sequencing, lru/dirty/valid updates
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module l2_cache_control (
	input  logic                                    clk,
	input  logic                                    arst_n_i,
	input  logic                                    cpu_read_i,
	input  logic                                    cpu_write_i,
	input  logic                                    mem_resp_i,
	output logic                                    cpu_resp_o,
	output logic                                    mem_read_o,
	output logic                                    mem_write_o,
	input  logic                                    hit,
	input  logic                                    tag0_comp,
	input  logic                                    tag1_comp,
	input  logic                                    lru_dataout,
	input  logic                                    valid0_dataout,
	input  logic                                    valid1_dataout,
	input  logic                                    dirty0_dataout,
	input  logic                                    dirty1_dataout,
	output logic                                    tag0_load,
	output logic                                    tag1_load,
	output logic                                    valid0_load,
	output logic                                    valid0_datain,
	output logic                                    valid1_load,
	output logic                                    valid1_datain,
	output logic                                    dirty0_load,
	output logic                                    dirty0_datain,
	output logic                                    dirty1_load,
	output logic                                    dirty1_datain,
	output logic                                    lru_load,
	output logic                                    lru_datain,
	output logic                                    arr_read,
	output l2_cache_pkg::data_write_en_sel_e        data0_write_en_sel,
	output l2_cache_pkg::data_write_en_sel_e        data1_write_en_sel,
	output l2_cache_pkg::data_out_sel_e             data_out_sel,
	output l2_cache_pkg::data_datain_sel_e          data0_datain_sel,
	output l2_cache_pkg::data_datain_sel_e          data1_datain_sel,
	output l2_cache_pkg::mem_addr_sel_e             mem_addr_sel
);

	localparam logic [1:0] S_IDLE      = 2'd0;
	localparam logic [1:0] S_CHECK     = 2'd1;
	localparam logic [1:0] S_WRITEBACK = 2'd2;
	localparam logic [1:0] S_FILL      = 2'd3;

	logic [1:0]                     state, next_state;
	logic                           hit_way0, hit_way1;
	l2_cache_pkg::data_datain_sel_e fill_din;

	assign hit_way0 = tag0_comp & valid0_dataout;
	assign hit_way1 = tag1_comp & valid1_dataout;
	assign fill_din = cpu_write_i ? l2_cache_pkg::r_data_mod : l2_cache_pkg::r_data;

	always_comb begin
		next_state         = state;
		arr_read           = 1'b0;
		mem_read_o         = 1'b0;
		mem_write_o        = 1'b0;
		tag0_load          = 1'b0;
		tag1_load          = 1'b0;
		valid0_load        = 1'b0;
		valid1_load        = 1'b0;
		valid0_datain      = 1'b1;	// only ever loaded on fill
		valid1_datain      = 1'b1;
		dirty0_load        = 1'b0;
		dirty1_load        = 1'b0;
		dirty0_datain      = cpu_write_i;	// writes dirty a line, read fills leave it clean
		dirty1_datain      = cpu_write_i;
		lru_load           = 1'b0;
		lru_datain         = hit_way0;	// point at the other way
		data0_write_en_sel = l2_cache_pkg::zero;
		data1_write_en_sel = l2_cache_pkg::zero;
		data0_datain_sel   = l2_cache_pkg::w_data;
		data1_datain_sel   = l2_cache_pkg::w_data;
		mem_addr_sel       = l2_cache_pkg::cpu_addr;
		data_out_sel       = hit_way0 ? l2_cache_pkg::data0_hit :
		                     hit_way1 ? l2_cache_pkg::data1_hit : l2_cache_pkg::no_hit;
		case (state)
			S_IDLE: begin
				// a held request in the response cycle is the one just served
				if ((cpu_read_i || cpu_write_i) && !cpu_resp_o) begin
					arr_read   = 1'b1;
					next_state = S_CHECK;
				end
			end
			S_CHECK: begin
				if (hit) begin
					lru_load = 1'b1;
					if (cpu_write_i) begin
						data0_write_en_sel = hit_way0 ? l2_cache_pkg::byte_enable
						                              : l2_cache_pkg::zero;
						data1_write_en_sel = hit_way0 ? l2_cache_pkg::zero
						                              : l2_cache_pkg::byte_enable;
						dirty0_load        = hit_way0;
						dirty1_load        = !hit_way0;
					end
					next_state = S_IDLE;
				end else if (lru_dataout ? dirty1_dataout : dirty0_dataout) begin
					next_state = S_WRITEBACK;
				end else begin
					next_state = S_FILL;
				end
			end
			S_WRITEBACK: begin
				mem_write_o  = 1'b1;
				mem_addr_sel = lru_dataout ? l2_cache_pkg::tag1_addr : l2_cache_pkg::tag0_addr;
				data_out_sel = lru_dataout ? l2_cache_pkg::data1_hit : l2_cache_pkg::data0_hit;
				if (mem_resp_i) begin
					next_state = S_FILL;
				end
			end
			default: begin	// S_FILL
				mem_read_o = 1'b1;
				if (mem_resp_i) begin
					tag0_load          = !lru_dataout;
					tag1_load          = lru_dataout;
					valid0_load        = !lru_dataout;
					valid1_load        = lru_dataout;
					dirty0_load        = !lru_dataout;
					dirty1_load        = lru_dataout;
					data0_write_en_sel = lru_dataout ? l2_cache_pkg::zero : l2_cache_pkg::all_ones;
					data1_write_en_sel = lru_dataout ? l2_cache_pkg::all_ones : l2_cache_pkg::zero;
					data0_datain_sel   = fill_din;
					data1_datain_sel   = fill_din;
					next_state         = S_CHECK;	// now hits
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state      <= S_IDLE;
			cpu_resp_o <= 1'b0;
		end else begin
			state      <= next_state;
			cpu_resp_o <= (state == S_CHECK) && hit;
		end
	end

	// only a valid line is ever written back
	assert property (@(posedge clk) disable iff (!arst_n_i)
		mem_write_o |-> (lru_dataout ? valid1_dataout : valid0_dataout));
	// the forwarded fill hits in the next check
	assert property (@(posedge clk) disable iff (!arst_n_i)
		(state == S_FILL && mem_resp_i) |=> hit);

endmodule

//--- src/l2_cache.sv
//////////////////////////////////////////////////////////////////////
// two-way set-associative L2 cache top level
// control FSM over the datapath
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_cache (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic [31:0]             cpu_address_i,
	input  logic                    cpu_read_i,
	input  logic                    cpu_write_i,
	input  logic [`L2_S_LINE-1:0]   cpu_wdata_i,
	input  logic [`L2_S_MASK-1:0]   cpu_byte_enable_i,
	output logic [`L2_S_LINE-1:0]   cpu_rdata_o,
	output logic                    cpu_resp_o,
	output logic [31:0]             mem_address_o,
	output logic                    mem_read_o,
	output logic                    mem_write_o,
	output logic [`L2_S_LINE-1:0]   mem_wdata_o,
	input  logic [`L2_S_LINE-1:0]   mem_rdata_i,
	input  logic                    mem_resp_i
);

	// array strobes
	logic tag0_load, tag1_load, lru_load, lru_datain, arr_read;
	logic valid0_load, valid0_datain, valid1_load, valid1_datain;
	logic dirty0_load, dirty0_datain, dirty1_load, dirty1_datain;

	// status back to control
	logic hit, tag0_comp, tag1_comp, lru_dataout;
	logic valid0_dataout, valid1_dataout, dirty0_dataout, dirty1_dataout;

	// mux selects
	l2_cache_pkg::data_write_en_sel_e data0_write_en_sel, data1_write_en_sel;
	l2_cache_pkg::data_out_sel_e      data_out_sel;
	l2_cache_pkg::data_datain_sel_e   data0_datain_sel, data1_datain_sel;
	l2_cache_pkg::mem_addr_sel_e      mem_addr_sel;

	l2_cache_control u_control (.*);

	l2_cache_datapath u_datapath (.*);

endmodule

//--- tests/l2_cache_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the two-way L2 cache
// random line requests, memory with random latency, reference model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "l2_cache_defs.svh"

module l2_cache_tb;

	localparam int num_ops    = 400;
	localparam int max_cycles = 8 + num_ops * 30;
	// four tags per set so that the two ways keep conflicting
	localparam logic [`L2_S_TAG-1:0] conflict_tags [4] = '{
		24'h000001, 24'h0a5a5a, 24'h3c7e19, 24'hfedcba
	};

	logic                  clk;
	logic                  arst_n_i;
	logic [31:0]           cpu_address_i;
	logic                  cpu_read_i;
	logic                  cpu_write_i;
	logic [`L2_S_LINE-1:0] cpu_wdata_i;
	logic [`L2_S_MASK-1:0] cpu_byte_enable_i;
	logic [`L2_S_LINE-1:0] cpu_rdata_o;
	logic                  cpu_resp_o;
	logic [31:0]           mem_address_o;
	logic                  mem_read_o;
	logic                  mem_write_o;
	logic [`L2_S_LINE-1:0] mem_wdata_o;
	logic [`L2_S_LINE-1:0] mem_rdata_i;
	logic                  mem_resp_i;

	logic [`L2_S_LINE-1:0] ref_lines [bit [31:0]];	// coherent view per line address
	logic [`L2_S_LINE-1:0] mem_lines [bit [31:0]];	// backing memory
	logic [`L2_S_TAG-1:0]  model_tag   [`L2_NUM_SETS][2];
	logic                  model_valid [`L2_NUM_SETS][2];
	logic                  model_dirty [`L2_NUM_SETS][2];
	logic                  model_lru   [`L2_NUM_SETS];	// way to evict next
	logic [31:0]           seed = 32'd9868;
	int                    cycles = 0;

	l2_cache UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_random();
		seed = xorshift32(seed);
		return seed;
	endfunction

	// power-up memory contents, each byte mixed from its full address
	function automatic logic [`L2_S_LINE-1:0] pattern_line(input logic [31:0] line_addr);
		logic [`L2_S_LINE-1:0] line;
		logic [31:0]           h;
		for (int i = 0; i < `L2_S_MASK; i++) begin
			h = xorshift32((line_addr | 32'(i)) ^ 32'h5bd1e995);
			line[8*i +: 8] = h[7:0] ^ h[31:24];
		end
		return line;
	endfunction

	function automatic logic [`L2_S_LINE-1:0] ref_line(input logic [31:0] a);
		return ref_lines.exists(a) ? ref_lines[a] : pattern_line(a);
	endfunction

	function automatic logic [`L2_S_LINE-1:0] backing_line(input logic [31:0] a);
		return mem_lines.exists(a) ? mem_lines[a] : pattern_line(a);
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic check_line(input string name, input logic [`L2_S_LINE-1:0] got,
			input logic [`L2_S_LINE-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input l2_cache_pkg::l2_addr_t got,
			input l2_cache_pkg::l2_addr_t exp);
		if (got.raw !== exp.raw) begin
			report_failure($sformatf("[ERROR] %s got %h expected %h", name, got.raw, exp.raw));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
		end
	endtask

	// memory answers 1 to 6 cycles after the request is seen
	task automatic answer_memory(input logic [`L2_S_LINE-1:0] line);
		int delay;
		delay = 1 + int'(next_random() % 6);
		repeat (delay - 1) begin
			@(negedge clk);
			check_bit("mem_read_o | mem_write_o", mem_read_o | mem_write_o, 1'b1);
		end
		@(posedge clk);
		mem_rdata_i <= line;
		mem_resp_i  <= 1'b1;
		@(posedge clk);
		mem_resp_i  <= 1'b0;
	endtask

	task automatic run_operation(input logic is_write, input l2_cache_pkg::l2_addr_t addr,
			input logic [`L2_S_LINE-1:0] wdata, input logic [`L2_S_MASK-1:0] be);
		l2_cache_pkg::l2_addr_t line_addr, victim_addr, got_addr;
		logic [`L2_S_INDEX-1:0] set;
		logic                   is_hit, hit_way, victim;
		logic                   wb_pending, fill_pending, done;
		logic [`L2_S_LINE-1:0]  merged;
		int                     waited;

		set             = addr.fields.index;
		line_addr.raw   = {addr.fields.tag, set, {`L2_S_OFFSET{1'b0}}};
		is_hit          = 1'b0;
		hit_way         = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (model_valid[set][w] && model_tag[set][w] == addr.fields.tag) begin
				is_hit  = 1'b1;
				hit_way = w[0];
			end
		end
		victim          = model_lru[set];
		victim_addr.raw = {model_tag[set][victim], set, {`L2_S_OFFSET{1'b0}}};
		wb_pending      = !is_hit && model_dirty[set][victim];
		fill_pending    = !is_hit;

		@(posedge clk);
		cpu_address_i     <= addr.raw;
		cpu_read_i        <= !is_write;
		cpu_write_i       <= is_write;
		cpu_wdata_i       <= wdata;
		cpu_byte_enable_i <= be;

		waited = 0;
		done   = 1'b0;
		while (!done) begin
			@(negedge clk);
			waited++;
			got_addr.raw = mem_address_o;
			if (mem_write_o) begin
				if (!wb_pending) begin
					report_failure("write-back issued that the model does not expect");
				end
				check_addr("mem_address_o", got_addr, victim_addr);
				check_line("mem_wdata_o", mem_wdata_o, ref_line(victim_addr.raw));
				mem_lines[victim_addr.raw] = mem_wdata_o;
				wb_pending = 1'b0;
				answer_memory('0);
			end else if (mem_read_o) begin
				if (wb_pending || !fill_pending) begin
					report_failure("fill request issued that the model does not expect");
				end
				check_addr("mem_address_o", got_addr, line_addr);	// line aligned
				fill_pending = 1'b0;
				answer_memory(backing_line(line_addr.raw));
			end else if (cpu_resp_o) begin
				if (wb_pending || fill_pending) begin
					report_failure("cpu response came before the expected memory traffic");
				end
				if (!is_write) begin
					check_line("cpu_rdata_o", cpu_rdata_o, ref_line(line_addr.raw));
				end
				done = 1'b1;
			end
			// hit answers 2 cycles after the request is sampled
			if (is_hit) begin
				check_bit("cpu_resp_o", cpu_resp_o, waited == 3);
			end
		end

		@(posedge clk);
		cpu_read_i  <= 1'b0;
		cpu_write_i <= 1'b0;

		merged = ref_line(line_addr.raw);
		if (is_write) begin
			for (int i = 0; i < `L2_S_MASK; i++) begin
				if (be[i]) begin
					merged[8*i +: 8] = wdata[8*i +: 8];
				end
			end
			ref_lines[line_addr.raw] = merged;
		end
		if (!is_hit) begin
			hit_way                  = victim;
			model_tag[set][victim]   = addr.fields.tag;
			model_valid[set][victim] = 1'b1;
			model_dirty[set][victim] = 1'b0;	// read fill is clean
		end
		if (is_write) begin
			model_dirty[set][hit_way] = 1'b1;
		end
		model_lru[set] = !hit_way;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			report_failure("timeout, the cache did not finish the requests in time");
		end
	end

	initial begin
		l2_cache_pkg::l2_addr_t addr;
		logic [`L2_S_LINE-1:0]  wdata;
		logic [31:0]            r;

		arst_n_i          = 1'b0;
		cpu_address_i     = '0;
		cpu_read_i        = 1'b0;
		cpu_write_i       = 1'b0;
		cpu_wdata_i       = '0;
		cpu_byte_enable_i = '0;
		mem_rdata_i       = '0;
		mem_resp_i        = 1'b0;
		for (int s = 0; s < `L2_NUM_SETS; s++) begin
			model_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				model_tag[s][w]   = '0;
				model_valid[s][w] = 1'b0;
				model_dirty[s][w] = 1'b0;
			end
		end

		repeat (8) @(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		check_bit("cpu_resp_o", cpu_resp_o, 1'b0);
		check_bit("mem_read_o", mem_read_o, 1'b0);
		check_bit("mem_write_o", mem_write_o, 1'b0);

		for (int n = 0; n < num_ops; n++) begin
			r                  = next_random();
			addr.fields.tag    = conflict_tags[r[1:0]];
			addr.fields.index  = r[4:2];
			addr.fields.offset = r[9:5];
			for (int w = 0; w < 8; w++) begin
				wdata[32*w +: 32] = next_random();
			end
			run_operation(r[10], addr, wdata, next_random());
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+include
src/l2_cache_pkg.sv
src/l2_cache_array.sv
src/l2_cache_data_array.sv
src/l2_cache_datapath.sv
src/l2_cache_control.sv
src/l2_cache.sv
tests/l2_cache_tb.sv

//--- Makefile
# Verilator build and run of the L2 cache testbench

TOP = l2_cache_tb
OBJ = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) \
		--Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP)

clean:
	rm -rf $(OBJ)
